//--- pcs_rx_pkg.sv
// 10GBASE-R receive PCS shared definitions: block format, control codes and payload views.

`default_nettype none

package pcs_rx_pkg;

    // ########################################################################
    // block format
    localparam int data_width = 64;
    localparam int hdr_width  = 2;

    localparam logic [hdr_width-1:0] hdr_data = 2'b01;
    localparam logic [hdr_width-1:0] hdr_ctrl = 2'b10;

    localparam int lock_blocks   = 64; // valid headers in a row to gain lock.
    localparam int unlock_errors = 16; // bad headers per 64 blocks that drop lock.
    localparam int ber_limit     = 16;

    // ########################################################################
    // block type field of a control block
    localparam logic [7:0] bt_idle   = 8'h1e;
    localparam logic [7:0] bt_start0 = 8'h78;
    localparam logic [7:0] bt_term0  = 8'h87;
    localparam logic [7:0] bt_term1  = 8'h99;
    localparam logic [7:0] bt_term2  = 8'haa;
    localparam logic [7:0] bt_term3  = 8'hb4;
    localparam logic [7:0] bt_term4  = 8'hcc;
    localparam logic [7:0] bt_term5  = 8'hd2;
    localparam logic [7:0] bt_term6  = 8'he1;
    localparam logic [7:0] bt_term7  = 8'hff;

    // xgmii control characters.
    localparam logic [7:0] xg_idle  = 8'h07;
    localparam logic [7:0] xg_start = 8'hfb;
    localparam logic [7:0] xg_term  = 8'hfd;
    localparam logic [7:0] xg_error = 8'hfe;

    // one descrambled payload word, read as data or as a control block.
    typedef union packed {
        logic [data_width/8-1:0][7:0] data_bytes; // byte 0 sits in the low bits.
        struct packed {
            logic [data_width-9:0] fields;
            logic [7:0]            block_type;
        } ctrl;
    } pcs_payload_t;

endpackage

`default_nettype wire

//--- pcs_rx_block_lock.sv
// Block lock FSM for 64b/66b alignment: checks sync headers and requests bitslips.

`timescale 1ns/1ps
`default_nettype none

module pcs_rx_block_lock #(
    parameter int BITSLIP_HOLD_CYCLES = 32
) (
    input  logic                           phy_rx_clk,
    input  logic                           rst_n,
    input  logic [pcs_rx_pkg::hdr_width-1:0] serdes_rx_hdr,
    output logic                           hdr_valid,
    output logic                           serdes_rx_bitslip,
    output logic                           block_lock
);
    import pcs_rx_pkg::*;

    localparam int win_blocks = 64;
    localparam int sh_w       = $clog2(lock_blocks);
    localparam int err_w      = $clog2(unlock_errors);
    localparam int win_w      = $clog2(win_blocks);
    localparam int hold_w     = $clog2(BITSLIP_HOLD_CYCLES + 1);

    logic [sh_w-1:0]   sh_count;   // valid headers in a row while hunting.
    logic [err_w-1:0]  err_count;  // bad headers in the current window.
    logic [win_w-1:0]  win_count;
    logic [hold_w-1:0] slip_hold;

    assign hdr_valid = (serdes_rx_hdr == hdr_data) || (serdes_rx_hdr == hdr_ctrl);

    always_ff @(posedge phy_rx_clk) begin
        if (!rst_n) begin
            sh_count          <= '0;
            err_count         <= '0;
            win_count         <= '0;
            slip_hold         <= '0;
            serdes_rx_bitslip <= 1'b0;
            block_lock        <= 1'b0;
        end else begin
            serdes_rx_bitslip <= 1'b0;
            if (slip_hold != '0) begin
                slip_hold <= slip_hold - 1'b1;
            end

            if (!block_lock) begin
                win_count <= '0;
                err_count <= '0;
                if (hdr_valid) begin
                    if (sh_count == sh_w'(lock_blocks - 1)) begin
                        block_lock <= 1'b1;
                        sh_count   <= '0;
                    end else begin
                        sh_count <= sh_count + 1'b1;
                    end
                end else begin
                    sh_count <= '0;
                    // the transceiver needs time to shift before the next slip.
                    if (slip_hold == '0) begin
                        serdes_rx_bitslip <= 1'b1;
                        slip_hold         <= hold_w'(BITSLIP_HOLD_CYCLES);
                    end
                end
            end else begin
                sh_count  <= '0;
                win_count <= win_count + 1'b1;
                if (!hdr_valid && err_count == err_w'(unlock_errors - 1)) begin
                    block_lock <= 1'b0;
                    err_count  <= '0;
                    win_count  <= '0;
                end else if (win_count == win_w'(win_blocks - 1)) begin
                    err_count <= '0; // a quiet enough window starts over.
                end else if (!hdr_valid) begin
                    err_count <= err_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- pcs_rx_descrambler.sv
// Self-synchronizing 1 + x^39 + x^58 descrambler stage with the sync header in step.

`timescale 1ns/1ps
`default_nettype none

module pcs_rx_descrambler (
    input  logic                            phy_rx_clk,
    input  logic                            rst_n,
    input  logic [pcs_rx_pkg::data_width-1:0] scr_data,
    input  logic [pcs_rx_pkg::hdr_width-1:0]  scr_hdr,
    input  logic                            scr_hdr_valid,
    output logic [pcs_rx_pkg::data_width-1:0] rx_data,
    output logic [pcs_rx_pkg::hdr_width-1:0]  rx_hdr,
    output logic                            rx_hdr_valid
);
    import pcs_rx_pkg::*;

    localparam int tap_far  = 58;
    localparam int tap_near = 39;

    logic [tap_far-1:0]            scr_state; // the msb is the newest bit.
    logic [data_width+tap_far-1:0] stream;
    logic [data_width-1:0]         descr;

    // serial order runs from the oldest history bit up to bit 63 of this word.
    assign stream = {scr_data, scr_state};

    always_comb begin
        for (int i = 0; i < data_width; i++) begin
            descr[i] = stream[tap_far + i] ^ stream[tap_far - tap_near + i] ^ stream[i];
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        scr_state <= stream[data_width+tap_far-1:data_width];
        rx_data   <= descr;
        rx_hdr    <= scr_hdr;
    end

    always_ff @(posedge phy_rx_clk) begin
        if (!rst_n) begin
            rx_hdr_valid <= 1'b0;
        end else begin
            rx_hdr_valid <= scr_hdr_valid;
        end
    end

endmodule

`default_nettype wire

//--- pcs_rx_decoder.sv
// 64b/66b block decoder stage that turns descrambled blocks into XGMII lanes.

`timescale 1ns/1ps
`default_nettype none

module pcs_rx_decoder (
    input  logic                              phy_rx_clk,
    input  logic                              rst_n,
    input  logic [pcs_rx_pkg::data_width-1:0]   rx_data,
    input  logic [pcs_rx_pkg::hdr_width-1:0]    rx_hdr,
    input  logic                              rx_hdr_valid,
    input  logic                              block_lock,
    output logic [pcs_rx_pkg::data_width-1:0]   xgmii_rxd,
    output logic [pcs_rx_pkg::data_width/8-1:0] xgmii_rxc,
    output logic                              rx_bad_block
);
    import pcs_rx_pkg::*;

    localparam int lanes = data_width / 8;

    pcs_payload_t          pl;
    logic [data_width-1:0] term_data;
    logic [3:0]            term_pos;  // 8 means the block is no terminate.
    logic [data_width-1:0] rxd_next;
    logic [lanes-1:0]      rxc_next;
    logic                  bad_next;

    assign pl = rx_data;

    // payload bytes 1 to 7 shifted down to lane 0.
    assign term_data = {xg_idle, pl.ctrl.fields};

    always_comb begin
        rxd_next = {lanes{xg_idle}};
        rxc_next = '1;
        bad_next = 1'b0;
        term_pos = 4'd8;

        if (block_lock) begin
            if (!rx_hdr_valid) begin
                bad_next = 1'b1;
            end else if (rx_hdr == hdr_data) begin
                rxd_next = pl.data_bytes;
                rxc_next = '0;
            end else begin
                case (pl.ctrl.block_type)
                    bt_idle: rxd_next = {lanes{xg_idle}};
                    bt_start0: begin
                        rxd_next = {pl.ctrl.fields, xg_start};
                        rxc_next = 8'h01;
                    end
                    bt_term0: term_pos = 4'd0;
                    bt_term1: term_pos = 4'd1;
                    bt_term2: term_pos = 4'd2;
                    bt_term3: term_pos = 4'd3;
                    bt_term4: term_pos = 4'd4;
                    bt_term5: term_pos = 4'd5;
                    bt_term6: term_pos = 4'd6;
                    bt_term7: term_pos = 4'd7;
                    default:  bad_next = 1'b1;
                endcase
            end

            if (term_pos != 4'd8) begin
                for (int j = 0; j < lanes; j++) begin
                    if (4'(j) < term_pos) begin
                        rxd_next[8*j +: 8] = term_data[8*j +: 8];
                        rxc_next[j]        = 1'b0;
                    end else if (4'(j) == term_pos) begin
                        rxd_next[8*j +: 8] = xg_term;
                        rxc_next[j]        = 1'b1;
                    end else begin
                        rxd_next[8*j +: 8] = xg_idle;
                        rxc_next[j]        = 1'b1;
                    end
                end
            end

            if (bad_next) begin
                rxd_next = {lanes{xg_error}};
                rxc_next = '1;
            end
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        if (!rst_n) begin
            xgmii_rxd    <= {lanes{xg_idle}};
            xgmii_rxc    <= '1;
            rx_bad_block <= 1'b0;
        end else begin
            xgmii_rxd    <= rxd_next;
            xgmii_rxc    <= rxc_next;
            rx_bad_block <= bad_next; // lines up with the error word.
        end
    end

endmodule

`default_nettype wire

//--- pcs_rx_ber_monitor.sv
// Header error monitor: high bit error rate window, total error count and link status.

`timescale 1ns/1ps
`default_nettype none

module pcs_rx_ber_monitor #(
    parameter int COUNT_125US = 19531
) (
    input  logic       phy_rx_clk,
    input  logic       rst_n,
    input  logic       hdr_valid,
    input  logic       block_lock,
    output logic [6:0] rx_error_count,
    output logic       rx_high_ber,
    output logic       rx_status
);
    import pcs_rx_pkg::*;

    localparam int timer_w = $clog2(COUNT_125US);
    localparam int ber_w   = $clog2(ber_limit + 1);

    logic [timer_w-1:0] win_timer;
    logic [ber_w-1:0]   ber_count;
    logic [ber_w-1:0]   ber_count_next;
    logic               hdr_err;
    logic               win_end;
    logic               high_ber_next;

    assign hdr_err = block_lock && !hdr_valid;
    assign win_end = (win_timer == timer_w'(COUNT_125US - 1));

    always_comb begin
        ber_count_next = ber_count;
        if (hdr_err && ber_count != ber_w'(ber_limit)) begin
            ber_count_next = ber_count + 1'b1; // holds at the limit.
        end
        high_ber_next = rx_high_ber;
        if (win_end) begin
            high_ber_next = (ber_count_next == ber_w'(ber_limit));
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        if (!rst_n) begin
            win_timer      <= '0;
            ber_count      <= '0;
            rx_error_count <= '0;
            rx_high_ber    <= 1'b0;
            rx_status      <= 1'b0;
        end else begin
            win_timer   <= win_end ? '0 : win_timer + 1'b1;
            ber_count   <= win_end ? '0 : ber_count_next;
            rx_high_ber <= high_ber_next;
            rx_status   <= block_lock && !high_ber_next;
            if (hdr_err && rx_error_count != 7'h7f) begin
                rx_error_count <= rx_error_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- pcs_rx_top.sv
// 10GBASE-R receive PCS top: block lock, descrambler, decoder and BER monitor.

`timescale 1ns/1ps
`default_nettype none

module pcs_rx_top #(
    parameter int BITSLIP_HOLD_CYCLES = 32,
    parameter int COUNT_125US         = 19531
) (
    input  logic                              phy_rx_clk,
    input  logic                              rst_n,
    input  logic [pcs_rx_pkg::data_width-1:0]   serdes_rx_data,
    input  logic [pcs_rx_pkg::hdr_width-1:0]    serdes_rx_hdr,
    output logic                              serdes_rx_bitslip,
    output logic [pcs_rx_pkg::data_width-1:0]   xgmii_rxd,
    output logic [pcs_rx_pkg::data_width/8-1:0] xgmii_rxc,
    output logic                              rx_block_lock,
    output logic                              rx_bad_block,
    output logic [6:0]                        rx_error_count,
    output logic                              rx_high_ber,
    output logic                              rx_status
);
    import pcs_rx_pkg::*;

    logic                  hdr_valid;
    logic [data_width-1:0] desc_data;
    logic [hdr_width-1:0]  desc_hdr;
    logic                  desc_hdr_valid;

    // ########################################################################
    // alignment and the two-stage payload path.
    pcs_rx_block_lock #(
        .BITSLIP_HOLD_CYCLES(BITSLIP_HOLD_CYCLES)
    ) u_block_lock (
        .phy_rx_clk        (phy_rx_clk),
        .rst_n             (rst_n),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .hdr_valid         (hdr_valid),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .block_lock        (rx_block_lock)
    );

    pcs_rx_descrambler u_descrambler (
        .phy_rx_clk    (phy_rx_clk),
        .rst_n         (rst_n),
        .scr_data      (serdes_rx_data),
        .scr_hdr       (serdes_rx_hdr),
        .scr_hdr_valid (hdr_valid),
        .rx_data       (desc_data),
        .rx_hdr        (desc_hdr),
        .rx_hdr_valid  (desc_hdr_valid)
    );

    pcs_rx_decoder u_decoder (
        .phy_rx_clk   (phy_rx_clk),
        .rst_n        (rst_n),
        .rx_data      (desc_data),
        .rx_hdr       (desc_hdr),
        .rx_hdr_valid (desc_hdr_valid),
        .block_lock   (rx_block_lock),
        .xgmii_rxd    (xgmii_rxd),
        .xgmii_rxc    (xgmii_rxc),
        .rx_bad_block (rx_bad_block)
    );

    // ########################################################################
    // side monitor, it sees headers at the same time as the lock FSM.
    pcs_rx_ber_monitor #(
        .COUNT_125US(COUNT_125US)
    ) u_ber_monitor (
        .phy_rx_clk     (phy_rx_clk),
        .rst_n          (rst_n),
        .hdr_valid      (hdr_valid),
        .block_lock     (rx_block_lock),
        .rx_error_count (rx_error_count),
        .rx_high_ber    (rx_high_ber),
        .rx_status      (rx_status)
    );

endmodule

`default_nettype wire

//--- tb_pcs_rx.sv
// Self-checking testbench for the 10GBASE-R receive PCS with a scrambler model and watchdog.

`timescale 1ns/1ps
`default_nettype none

module tb_pcs_rx;
    import pcs_rx_pkg::*;

    localparam int bitslip_hold = 4;
    localparam int ber_window   = 200;
    localparam int n_junk       = 30;
    localparam int n_mix        = 42;
    localparam int n_err_test   = 10;
    localparam int n_ber_err    = 400;
    localparam int n_ber_clean  = 420;
    localparam int n_unlock_max = 40;
    localparam int n_blocks     = 3 + n_junk + lock_blocks + 2 + n_mix + n_err_test
                                  + n_ber_err + n_ber_clean + n_unlock_max + 3;
    localparam longint watchdog_ns = longint'(n_blocks + 1000) * 20;

    localparam logic [7:0][7:0] term_codes = {bt_term7, bt_term6, bt_term5, bt_term4,
                                              bt_term3, bt_term2, bt_term1, bt_term0};

    typedef struct packed {
        logic [data_width-1:0] rxd;
        logic [7:0]            rxc;
        logic                  bad;
        logic                  check; // set only where the lock is known to hold.
    } exp_t;

    logic                  phy_rx_clk;
    logic                  rst_n;
    logic [data_width-1:0] serdes_rx_data;
    logic [hdr_width-1:0]  serdes_rx_hdr;
    logic                  serdes_rx_bitslip;
    logic [data_width-1:0] xgmii_rxd;
    logic [7:0]            xgmii_rxc;
    logic                  rx_block_lock;
    logic                  rx_bad_block;
    logic [6:0]            rx_error_count;
    logic                  rx_high_ber;
    logic                  rx_status;

    exp_t        exp_q[$];
    logic [57:0] scr_hist;   // index 0 is the newest scrambled bit.
    int          errors        = 0;
    int          pass_count    = 0;
    int          fail_count    = 0;
    int          exp_err_total = 0;
    int          cycle         = 0;
    int          last_slip     = -1000;
    int          slip_count    = 0;

    pcs_rx_top #(
        .BITSLIP_HOLD_CYCLES(bitslip_hold),
        .COUNT_125US        (ber_window)
    ) dut0 (
        .phy_rx_clk        (phy_rx_clk),
        .rst_n             (rst_n),
        .serdes_rx_data    (serdes_rx_data),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .xgmii_rxd         (xgmii_rxd),
        .xgmii_rxc         (xgmii_rxc),
        .rx_block_lock     (rx_block_lock),
        .rx_bad_block      (rx_bad_block),
        .rx_error_count    (rx_error_count),
        .rx_high_ber       (rx_high_ber),
        .rx_status         (rx_status)
    );

    always #10 phy_rx_clk = ~phy_rx_clk;

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Test failures found");
        $finish;
    end

    // ########################################################################
    // helpers

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s expected %0h got %0h", name, expected, got);
            errors++;
        end
    endtask

    // serial scrambler, bit 0 goes out first.
    function automatic logic [63:0] scramble_block(input logic [63:0] plain);
        logic [63:0] scr;
        logic        b;
        for (int i = 0; i < 64; i++) begin
            b        = plain[i] ^ scr_hist[38] ^ scr_hist[57];
            scr_hist = {scr_hist[56:0], b};
            scr[i]   = b;
        end
        return scr;
    endfunction

    task automatic send_block(input logic [1:0] hdr, input pcs_payload_t plain,
                              input logic [63:0] rxd, input logic [7:0] rxc,
                              input logic bad, input logic check);
        exp_t e;
        e = {rxd, rxc, bad, check};
        @(posedge phy_rx_clk);
        serdes_rx_hdr  <= hdr;
        serdes_rx_data <= scramble_block(plain);
        exp_q.push_back(e);
    endtask

    task automatic send_data(input logic check);
        pcs_payload_t p;
        p = {$urandom, $urandom};
        send_block(hdr_data, p, p, 8'h00, 1'b0, check);
    endtask

    task automatic send_bad_hdr(input logic check);
        pcs_payload_t p;
        logic [1:0]   hdr;
        p   = {$urandom, $urandom};
        hdr = ($urandom % 2 == 1) ? 2'b11 : 2'b00;
        if (check) begin
            exp_err_total++;
        end
        send_block(hdr, p, {8{xg_error}}, 8'hff, 1'b1, check);
    endtask

    task automatic send_ctrl(input logic [7:0] bt, input logic check);
        pcs_payload_t p;
        logic [63:0]  rxd;
        logic [7:0]   rxc;
        logic         bad;
        int           k;
        p               = {$urandom, $urandom};
        p.ctrl.block_type = bt;
        rxd = {8{xg_idle}};
        rxc = 8'hff;
        bad = 1'b0;
        k   = -1;
        for (int t = 0; t < 8; t++) begin
            if (bt == term_codes[t]) k = t;
        end
        if (bt == bt_start0) begin
            rxd[7:0] = xg_start;
            for (int i = 1; i < 8; i++) rxd[8*i +: 8] = p.data_bytes[i];
            rxc = 8'h01;
        end else if (k >= 0) begin
            for (int i = 0; i < 8; i++) begin
                if (i < k) begin
                    rxd[8*i +: 8] = p.data_bytes[i+1]; // data shifts down past the type byte.
                    rxc[i]        = 1'b0;
                end else if (i == k) begin
                    rxd[8*i +: 8] = xg_term;
                end
            end
        end else if (bt != bt_idle) begin
            rxd = {8{xg_error}};
            bad = 1'b1;
        end
        send_block(hdr_ctrl, p, rxd, rxc, bad, check);
    endtask

    task automatic check_reset_outputs();
        check_value("serdes_rx_bitslip", serdes_rx_bitslip, 0);
        check_value("rx_block_lock", rx_block_lock, 0);
        check_value("rx_bad_block", rx_bad_block, 0);
        check_value("rx_high_ber", rx_high_ber, 0);
        check_value("rx_status", rx_status, 0);
        check_value("rx_error_count", rx_error_count, 0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s with %0d errors", name, errors - errors_before);
        end
    endtask

    // ########################################################################
    // monitors, sampled mid-cycle where the outputs are stable

    always @(negedge phy_rx_clk) begin
        cycle++;
        if (serdes_rx_bitslip) begin
            slip_count++;
            assert (cycle - last_slip >= bitslip_hold) else begin
                $display("bitslip pulses came only %0d cycles apart", cycle - last_slip);
                errors++;
            end
            last_slip = cycle;
        end
    end

    // the word at the queue front was presented two edges ago.
    always @(negedge phy_rx_clk) begin
        exp_t e;
        if (exp_q.size() >= 3) begin
            e = exp_q.pop_front();
            if (e.check) begin
                check_value("rx_block_lock", rx_block_lock, 1);
                check_value("xgmii_rxd", xgmii_rxd, e.rxd);
                check_value("xgmii_rxc", xgmii_rxc, e.rxc);
                check_value("rx_bad_block", rx_bad_block, e.bad);
            end
        end
    end

    // ########################################################################
    // test sequence

    initial begin
        int   mark;
        int   sent;
        logic saw_high;
        void'($urandom(32'h602b_8e84));
        phy_rx_clk     = 1'b0;
        rst_n          = 1'b0;
        serdes_rx_data = '0;
        serdes_rx_hdr  = 2'b00;
        scr_hist       = '0;

        mark = errors;
        repeat (2) begin
            @(posedge phy_rx_clk);
            @(negedge phy_rx_clk);
            check_reset_outputs();
        end
        @(posedge phy_rx_clk);
        rst_n <= 1'b1; // this edge still samples reset.
        @(negedge phy_rx_clk);
        check_reset_outputs();
        finish_test("reset_state", mark);

        mark = errors;
        repeat (n_junk) send_bad_hdr(1'b0);
        repeat (lock_blocks) send_ctrl(bt_idle, 1'b0);
        @(negedge phy_rx_clk);
        check_value("rx_block_lock", rx_block_lock, 0); // 63 valid headers taken so far.
        send_ctrl(bt_idle, 1'b0);
        @(negedge phy_rx_clk);
        check_value("rx_block_lock", rx_block_lock, 1);
        send_ctrl(bt_idle, 1'b0);
        @(negedge phy_rx_clk);
        check_value("rx_status", rx_status, 1);
        assert (slip_count > 0) else begin
            $display("no bitslip was requested while hunting for alignment");
            errors++;
        end
        finish_test("alignment", mark);

        mark = errors;
        repeat (16) send_data(1'b1);
        for (int t = 0; t < 8; t++) begin
            send_ctrl(bt_start0, 1'b1);
            send_data(1'b1);
            send_ctrl(term_codes[t], 1'b1);
        end
        repeat (2) send_ctrl(bt_idle, 1'b1);
        finish_test("data_decoding", mark);

        mark = errors;
        send_data(1'b1);
        send_bad_hdr(1'b1);
        send_data(1'b1);
        send_ctrl(8'h2d, 1'b1);
        send_data(1'b1);
        send_ctrl(8'h55, 1'b1);
        send_bad_hdr(1'b1);
        repeat (3) send_data(1'b1);
        @(negedge phy_rx_clk);
        check_value("rx_error_count", rx_error_count, exp_err_total);
        finish_test("error_blocks", mark);

        // one error every 10 blocks stays under 16 per 64-block lock window.
        mark     = errors;
        saw_high = 1'b0;
        for (int i = 0; i < n_ber_err; i++) begin
            if (i % 10 == 5) begin
                send_bad_hdr(1'b1);
            end else begin
                send_data(1'b1);
            end
            @(negedge phy_rx_clk);
            if (rx_high_ber) begin
                saw_high = 1'b1;
                check_value("rx_status", rx_status, 0);
            end
        end
        assert (saw_high) else begin
            $display("high bit error rate was never flagged during the error burst");
            errors++;
        end
        check_value("rx_block_lock", rx_block_lock, 1);
        repeat (n_ber_clean) send_data(1'b1);
        @(negedge phy_rx_clk);
        check_value("rx_high_ber", rx_high_ber, 0);
        check_value("rx_status", rx_status, 1);
        check_value("rx_error_count", rx_error_count, exp_err_total);
        finish_test("high_ber", mark);

        mark = errors;
        sent = 0;
        while (rx_block_lock && sent < n_unlock_max) begin
            send_bad_hdr(1'b0);
            sent++;
            @(negedge phy_rx_clk);
        end
        // the block sent last has not been taken yet when the drop shows.
        assert (!rx_block_lock && sent - 1 >= unlock_errors && sent - 1 <= 2 * unlock_errors)
        else begin
            $display("block lock did not drop as expected, %0d invalid headers sent", sent);
            errors++;
        end
        repeat (3) send_data(1'b0);
        @(negedge phy_rx_clk);
        check_value("xgmii_rxd", xgmii_rxd, {8{xg_idle}});
        check_value("xgmii_rxc", xgmii_rxc, 8'hff);
        check_value("rx_bad_block", rx_bad_block, 0);
        check_value("rx_status", rx_status, 0);
        finish_test("loss_of_lock", mark);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
pcs_rx_pkg.sv
pcs_rx_block_lock.sv
pcs_rx_descrambler.sv
pcs_rx_decoder.sv
pcs_rx_ber_monitor.sv
pcs_rx_top.sv
tb_pcs_rx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcs_rx
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
